// ==== Makefile ====
SIM      := verilator
SIMFLAGS := --binary --timing -j 0
TOP      := pipeline_tb
FILELIST := filelist.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log

SOURCES  := $(shell grep -v '^+' $(FILELIST))
HEADERS  := $(wildcard hw/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --Mdir $(BUILD) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== filelist.f ====
+incdir+hw
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/pipeline_control.sv
hw/pipeline_top.sv
test/pipeline_tb.sv

// ==== hw/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath and instruction width
`define CPU_WIDTH 16
`define CPU_REGS 16

// Word counts of the two memories
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

// Store address of the output register
`define IO_ADDR 16'hFFFF

`endif

// ==== hw/cpu_pkg.sv ====
`default_nettype none

`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`CPU_WIDTH-1:0] word_t;
    typedef logic [$clog2(`CPU_REGS)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        AND  = 4'h2,
        OR   = 4'h3,
        SLT  = 4'h4,
        LI   = 4'h5,
        ADDI = 4'h6,
        LW   = 4'h7,
        SW   = 4'h8,
        BEQZ = 4'h9,
        BNEZ = 4'hA,
        HALT = 4'hB,
        NOP  = 4'hF
    } opcode_t;

    // Register format, rt doubles as the memory offset
    typedef struct packed {
        opcode_t  op;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
    } r_fmt_t;

    // Immediate format
    typedef struct packed {
        opcode_t    op;
        reg_idx_t   rd;
        logic [7:0] imm8;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_t;

    // Forwarding select encoding
    localparam logic [1:0] FWD_REG = 2'd0;
    localparam logic [1:0] FWD_MEM = 2'd1;
    localparam logic [1:0] FWD_WB  = 2'd2;

endpackage

`default_nettype wire

// ==== hw/decode_stage.sv ====
`default_nettype none

`include "cpu_config.svh"

module decode_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              id_clear,
    input  logic              if_valid,
    input  cpu_pkg::word_t    if_pc,
    input  cpu_pkg::instr_t   if_instr,
    input  logic              wb_we,
    input  cpu_pkg::reg_idx_t wb_rd,
    input  cpu_pkg::word_t    wb_data,
    output cpu_pkg::reg_idx_t id_rs,
    output cpu_pkg::reg_idx_t id_rt,
    output logic              id_uses_rs,
    output logic              id_uses_rt,
    output logic              id_halt,
    output logic              ex_valid,
    output logic              ex_reg_write,
    output logic              ex_mem_read,
    output logic              ex_mem_write,
    output logic              ex_is_branch,
    output logic              ex_branch_on_zero,
    output logic              ex_halt,
    output cpu_pkg::opcode_t  ex_op,
    output cpu_pkg::reg_idx_t ex_rd,
    output cpu_pkg::reg_idx_t ex_rs,
    output cpu_pkg::reg_idx_t ex_rt,
    output cpu_pkg::word_t    ex_a,
    output cpu_pkg::word_t    ex_b,
    output cpu_pkg::word_t    ex_imm,
    output cpu_pkg::word_t    ex_pc
);

    cpu_pkg::word_t    regs [`CPU_REGS];
    cpu_pkg::opcode_t  op;
    cpu_pkg::reg_idx_t rd;
    cpu_pkg::word_t    imm;
    cpu_pkg::word_t    rs_val;
    cpu_pkg::word_t    rt_val;
    logic              reg_write;
    logic              mem_read;
    logic              mem_write;
    logic              is_branch;
    logic              on_zero;

    assign op      = if_instr.i_fmt.op;
    assign rd      = if_instr.i_fmt.rd;
    assign id_halt = (op == cpu_pkg::HALT);

    always_comb
    begin
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        is_branch  = 1'b0;
        on_zero    = 1'b0;
        id_uses_rs = 1'b0;
        id_uses_rt = 1'b0;
        id_rs      = if_instr.r_fmt.rs;
        id_rt      = if_instr.r_fmt.rt;
        imm        = cpu_pkg::word_t'($signed(if_instr.i_fmt.imm8));
        case (op)
            cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::AND, cpu_pkg::OR, cpu_pkg::SLT:
            begin
                reg_write  = 1'b1;
                id_uses_rs = 1'b1;
                id_uses_rt = 1'b1;
            end
            cpu_pkg::LI:
                reg_write = 1'b1;
            // rd is both source and destination
            cpu_pkg::ADDI:
            begin
                reg_write  = 1'b1;
                id_uses_rs = 1'b1;
                id_rs      = rd;
            end
            cpu_pkg::LW:
            begin
                reg_write  = 1'b1;
                mem_read   = 1'b1;
                id_uses_rs = 1'b1;
                imm        = cpu_pkg::word_t'($signed(if_instr.r_fmt.rt));
            end
            // Store data comes out of the rt port
            cpu_pkg::SW:
            begin
                mem_write  = 1'b1;
                id_uses_rs = 1'b1;
                id_uses_rt = 1'b1;
                id_rt      = rd;
                imm        = cpu_pkg::word_t'($signed(if_instr.r_fmt.rt));
            end
            cpu_pkg::BEQZ, cpu_pkg::BNEZ:
            begin
                is_branch  = 1'b1;
                on_zero    = (op == cpu_pkg::BEQZ);
                id_uses_rt = 1'b1;
                id_rt      = rd;
            end
            default:
                ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (wb_we && wb_rd != '0)
            regs[wb_rd] <= wb_data;
    end

    // Write-first, r0 reads zero
    assign rs_val = (id_rs == '0) ? '0 :
                    (wb_we && wb_rd == id_rs) ? wb_data : regs[id_rs];
    assign rt_val = (id_rt == '0) ? '0 :
                    (wb_we && wb_rd == id_rt) ? wb_data : regs[id_rt];

    // ID/EXE register
    always_ff @(posedge clk)
    begin
        if (reset || id_clear || !if_valid)
        begin
            ex_valid          <= 1'b0;
            ex_reg_write      <= 1'b0;
            ex_mem_read       <= 1'b0;
            ex_mem_write      <= 1'b0;
            ex_is_branch      <= 1'b0;
            ex_branch_on_zero <= 1'b0;
            ex_halt           <= 1'b0;
        end
        else
        begin
            ex_valid          <= 1'b1;
            ex_reg_write      <= reg_write;
            ex_mem_read       <= mem_read;
            ex_mem_write      <= mem_write;
            ex_is_branch      <= is_branch;
            ex_branch_on_zero <= on_zero;
            ex_halt           <= id_halt;
        end
    end

    always_ff @(posedge clk)
    begin
        ex_op  <= op;
        ex_rd  <= rd;
        ex_rs  <= id_rs;
        ex_rt  <= id_rt;
        ex_a   <= rs_val;
        ex_b   <= rt_val;
        ex_imm <= imm;
        ex_pc  <= if_pc;
    end

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`default_nettype none

module execute_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              ex_valid,
    input  logic              ex_reg_write,
    input  logic              ex_mem_read,
    input  logic              ex_mem_write,
    input  logic              ex_is_branch,
    input  logic              ex_branch_on_zero,
    input  logic              ex_halt,
    input  cpu_pkg::opcode_t  ex_op,
    input  cpu_pkg::reg_idx_t ex_rd,
    input  cpu_pkg::reg_idx_t ex_rs,
    input  cpu_pkg::reg_idx_t ex_rt,
    input  cpu_pkg::word_t    ex_a,
    input  cpu_pkg::word_t    ex_b,
    input  cpu_pkg::word_t    ex_imm,
    input  cpu_pkg::word_t    ex_pc,
    input  logic [1:0]        fwd_a,
    input  logic [1:0]        fwd_b,
    input  cpu_pkg::word_t    mem_result,
    input  cpu_pkg::word_t    wb_data,
    output logic              branch_taken,
    output cpu_pkg::word_t    branch_target,
    output logic              mem_valid,
    output logic              mem_reg_write,
    output logic              mem_read,
    output logic              mem_write,
    output logic              mem_halt,
    output cpu_pkg::reg_idx_t mem_rd,
    output cpu_pkg::word_t    mem_alu,
    output cpu_pkg::word_t    mem_store
);

    cpu_pkg::word_t a;
    cpu_pkg::word_t b;
    cpu_pkg::word_t result;

    // An r0 source keeps its zero from the register file
    function automatic cpu_pkg::word_t pick(input logic [1:0] sel,
                                            input cpu_pkg::reg_idx_t src,
                                            input cpu_pkg::word_t rf_val);
        if (src == '0)
            return rf_val;
        case (sel)
            cpu_pkg::FWD_MEM: return mem_result;
            cpu_pkg::FWD_WB:  return wb_data;
            default:          return rf_val;
        endcase
    endfunction

    always_comb
    begin
        a = pick(fwd_a, ex_rs, ex_a);
        b = pick(fwd_b, ex_rt, ex_b);
    end

    always_comb
    begin
        case (ex_op)
            cpu_pkg::ADD:  result = a + b;
            cpu_pkg::SUB:  result = a - b;
            cpu_pkg::AND:  result = a & b;
            cpu_pkg::OR:   result = a | b;
            cpu_pkg::SLT:  result = cpu_pkg::word_t'($signed(a) < $signed(b));
            cpu_pkg::LI:   result = ex_imm;
            // ADDI and memory addresses
            cpu_pkg::ADDI, cpu_pkg::LW, cpu_pkg::SW:
                result = a + ex_imm;
            default:       result = '0;
        endcase
    end

    // Branch tests the rd value on the b side
    assign branch_taken  = ex_is_branch && ((b == '0) == ex_branch_on_zero);
    assign branch_target = ex_pc + 1'b1 + ex_imm;

    ////////////////////////////////////////////////////////////
    // EXE/MEM register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mem_valid     <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_read      <= 1'b0;
            mem_write     <= 1'b0;
            mem_halt      <= 1'b0;
        end
        else
        begin
            mem_valid     <= ex_valid;
            mem_reg_write <= ex_reg_write;
            mem_read      <= ex_mem_read;
            mem_write     <= ex_mem_write;
            mem_halt      <= ex_halt;
        end
    end

    always_ff @(posedge clk)
    begin
        mem_rd    <= ex_rd;
        mem_alu   <= result;
        mem_store <= b;
    end

endmodule

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`default_nettype none

`include "cpu_config.svh"

module fetch_stage (
    input  logic            clk,
    input  logic            reset,
    input  logic            pc_keep,
    input  logic            if_keep,
    input  logic            if_clear,
    input  logic            branch_taken,
    input  cpu_pkg::word_t  branch_target,
    input  logic            prog_we,
    input  cpu_pkg::word_t  prog_addr,
    input  cpu_pkg::instr_t prog_data,
    output cpu_pkg::word_t  if_pc,
    output cpu_pkg::instr_t if_instr,
    output logic            if_valid
);

    localparam int IMEM_AW = $clog2(`IMEM_DEPTH);

    cpu_pkg::word_t  pc;
    cpu_pkg::instr_t imem [`IMEM_DEPTH];
    cpu_pkg::instr_t fetched;

    // Program load port
    always_ff @(posedge clk)
    begin
        if (prog_we)
            imem[prog_addr[IMEM_AW-1:0]] <= prog_data;
    end

    assign fetched = imem[pc[IMEM_AW-1:0]];

    // Redirect wins over any hold
    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= '0;
        else if (branch_taken)
            pc <= branch_target;
        else if (!pc_keep)
            pc <= pc + 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // IF/ID register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || if_clear)
            if_valid <= 1'b0;
        else if (!if_keep)
            if_valid <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!if_keep)
        begin
            if_pc    <= pc;
            if_instr <= fetched;
        end
    end

endmodule

`default_nettype wire

// ==== hw/memory_stage.sv ====
`default_nettype none

`include "cpu_config.svh"

module memory_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              mem_valid,
    input  logic              mem_reg_write,
    input  logic              mem_read,
    input  logic              mem_write,
    input  logic              mem_halt,
    input  cpu_pkg::reg_idx_t mem_rd,
    input  cpu_pkg::word_t    mem_alu,
    input  cpu_pkg::word_t    mem_store,
    output cpu_pkg::word_t    mem_result,
    output logic              wb_we,
    output cpu_pkg::reg_idx_t wb_rd,
    output cpu_pkg::word_t    wb_data,
    output logic              io_valid,
    output cpu_pkg::word_t    io_data,
    output logic              halted
);

    localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

    cpu_pkg::word_t dmem [`DMEM_DEPTH];
    cpu_pkg::word_t load_data;
    cpu_pkg::word_t wb_alu;
    cpu_pkg::word_t wb_load;
    logic           is_io;
    logic           store_en;
    logic           wb_mem_read;
    logic           wb_halt;

    assign is_io    = (mem_alu == `IO_ADDR);
    assign store_en = mem_valid && mem_write;

    // Data memory, the output address is not backed by a word
    always_ff @(posedge clk)
    begin
        if (store_en && !is_io)
            dmem[mem_alu[DMEM_AW-1:0]] <= mem_store;
    end

    assign load_data  = dmem[mem_alu[DMEM_AW-1:0]];
    assign mem_result = mem_alu;

    // Output register
    always_ff @(posedge clk)
    begin
        if (reset)
            io_valid <= 1'b0;
        else
            io_valid <= store_en && is_io;
    end

    always_ff @(posedge clk)
    begin
        if (store_en && is_io)
            io_data <= mem_store;
    end

    ////////////////////////////////////////////////////////////
    // MEM/WB register and write-back
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wb_we       <= 1'b0;
            wb_mem_read <= 1'b0;
            wb_halt     <= 1'b0;
            halted      <= 1'b0;
        end
        else
        begin
            wb_we       <= mem_valid && mem_reg_write;
            wb_mem_read <= mem_read;
            wb_halt     <= mem_valid && mem_halt;
            // Sticky once the HALT retires
            halted      <= halted || wb_halt;
        end
    end

    always_ff @(posedge clk)
    begin
        wb_rd   <= mem_rd;
        wb_alu  <= mem_alu;
        wb_load <= load_data;
    end

    assign wb_data = wb_mem_read ? wb_load : wb_alu;

endmodule

`default_nettype wire

// ==== hw/pipeline_control.sv ====
`default_nettype none

module pipeline_control (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::reg_idx_t id_rs,
    input  cpu_pkg::reg_idx_t id_rt,
    input  logic              id_uses_rs,
    input  logic              id_uses_rt,
    input  logic              id_halt,
    input  logic              if_valid,
    input  logic              ex_valid,
    input  cpu_pkg::reg_idx_t ex_rd,
    input  logic              ex_reg_write,
    input  logic              ex_mem_read,
    input  logic              branch_taken,
    input  cpu_pkg::reg_idx_t mem_rd,
    input  logic              mem_reg_write,
    input  cpu_pkg::reg_idx_t wb_rd,
    input  logic              wb_we,
    output logic              pc_keep,
    output logic              if_keep,
    output logic              if_clear,
    output logic              id_clear,
    output logic [1:0]        fwd_a,
    output logic [1:0]        fwd_b
);

    cpu_pkg::reg_idx_t src_a;
    cpu_pkg::reg_idx_t src_b;
    logic              use_a;
    logic              use_b;
    logic              load_use;
    logic              halt_seen;
    logic              halt_hold;

    // Newer stage wins, r0 is never forwarded
    function automatic logic [1:0] fwd_sel(input logic used, input cpu_pkg::reg_idx_t src);
        if (!used || src == '0)
            return cpu_pkg::FWD_REG;
        if (mem_reg_write && mem_rd == src)
            return cpu_pkg::FWD_MEM;
        if (wb_we && wb_rd == src)
            return cpu_pkg::FWD_WB;
        return cpu_pkg::FWD_REG;
    endfunction

    assign load_use = if_valid && ex_valid && ex_mem_read && ex_reg_write && ex_rd != '0 &&
                      ((id_uses_rs && id_rs == ex_rd) || (id_uses_rt && id_rt == ex_rd));
    assign halt_seen = if_valid && id_halt;

    assign pc_keep  = load_use || halt_seen || halt_hold;
    assign if_keep  = load_use;
    assign if_clear = branch_taken || halt_seen || halt_hold;
    assign id_clear = branch_taken || load_use;

    // A HALT squashed by a taken branch never sets the hold
    always_ff @(posedge clk)
    begin
        if (reset)
            halt_hold <= 1'b0;
        else if (halt_seen && !branch_taken)
            halt_hold <= 1'b1;
    end

    // Sources of the instruction now in execute
    always_ff @(posedge clk)
    begin
        if (reset || id_clear || !if_valid)
        begin
            use_a <= 1'b0;
            use_b <= 1'b0;
        end
        else
        begin
            use_a <= id_uses_rs;
            use_b <= id_uses_rt;
        end
    end

    always_ff @(posedge clk)
    begin
        src_a <= id_rs;
        src_b <= id_rt;
    end

    always_comb
    begin
        fwd_a = fwd_sel(use_a, src_a);
        fwd_b = fwd_sel(use_b, src_b);
    end

endmodule

`default_nettype wire

// ==== hw/pipeline_top.sv ====
`default_nettype none

module pipeline_top (
    input  logic            clk,
    input  logic            reset,
    input  logic            prog_we,
    input  cpu_pkg::word_t  prog_addr,
    input  cpu_pkg::instr_t prog_data,
    output logic            io_valid,
    output cpu_pkg::word_t  io_data,
    output logic            halted
);

    // Hazard and forwarding controls
    logic              pc_keep;
    logic              if_keep;
    logic              if_clear;
    logic              id_clear;
    logic [1:0]        fwd_a;
    logic [1:0]        fwd_b;

    // IF/ID and decode sources
    cpu_pkg::word_t    if_pc;
    cpu_pkg::instr_t   if_instr;
    logic              if_valid;
    cpu_pkg::reg_idx_t id_rs;
    cpu_pkg::reg_idx_t id_rt;
    logic              id_uses_rs;
    logic              id_uses_rt;
    logic              id_halt;

    // ID/EXE
    logic              ex_valid;
    logic              ex_reg_write;
    logic              ex_mem_read;
    logic              ex_mem_write;
    logic              ex_is_branch;
    logic              ex_branch_on_zero;
    logic              ex_halt;
    cpu_pkg::opcode_t  ex_op;
    cpu_pkg::reg_idx_t ex_rd;
    cpu_pkg::reg_idx_t ex_rs;
    cpu_pkg::reg_idx_t ex_rt;
    cpu_pkg::word_t    ex_a;
    cpu_pkg::word_t    ex_b;
    cpu_pkg::word_t    ex_imm;
    cpu_pkg::word_t    ex_pc;
    logic              branch_taken;
    cpu_pkg::word_t    branch_target;

    // EXE/MEM and write-back
    logic              mem_valid;
    logic              mem_reg_write;
    logic              mem_read;
    logic              mem_write;
    logic              mem_halt;
    cpu_pkg::reg_idx_t mem_rd;
    cpu_pkg::word_t    mem_alu;
    cpu_pkg::word_t    mem_store;
    cpu_pkg::word_t    mem_result;
    logic              wb_we;
    cpu_pkg::reg_idx_t wb_rd;
    cpu_pkg::word_t    wb_data;

    fetch_stage fetch_stage_inst (.*);

    decode_stage decode_stage_inst (.*);

    execute_stage execute_stage_inst (.*);

    memory_stage memory_stage_inst (.*);

    pipeline_control pipeline_control_inst (.*);

endmodule

`default_nettype wire

// ==== test/pipeline_tb.sv ====
`default_nettype none

`include "cpu_config.svh"

module pipeline_tb;

    logic            clk;
    logic            reset;
    logic            prog_we;
    cpu_pkg::word_t  prog_addr;
    cpu_pkg::instr_t prog_data;
    logic            io_valid;
    cpu_pkg::word_t  io_data;
    logic            halted;

    // Program image and reference model
    cpu_pkg::instr_t image [`IMEM_DEPTH];
    int              prog_len;
    cpu_pkg::word_t  model_regs [`CPU_REGS];
    cpu_pkg::word_t  model_mem [`DMEM_DEPTH];
    cpu_pkg::word_t  expected [$];
    cpu_pkg::word_t  got [$];

    pipeline_top pipeline_top_inst (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .io_valid  (io_valid),
        .io_data   (io_data),
        .halted    (halted)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Failure reporting and checks
    ////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input cpu_pkg::word_t exp_val,
                              input cpu_pkg::word_t act_val);
        if (act_val !== exp_val)
        begin
            $display("Fail at time %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int exp_val, input int act_val);
        if (act_val != exp_val)
        begin
            $display("Fail at time %0t: %s expected %0d, got %0d", $time, name, exp_val, act_val);
            abort_run();
        end
    endtask

    task automatic check_halted(input logic exp_val, input logic act_val);
        if (act_val !== exp_val)
        begin
            $display("Fail at time %0t: halted expected %b, got %b", $time, exp_val, act_val);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Program builder
    ////////////////////////////////////////////////////////////

    function automatic cpu_pkg::instr_t r_word(input cpu_pkg::opcode_t op,
                                               input cpu_pkg::reg_idx_t rd,
                                               input cpu_pkg::reg_idx_t rs,
                                               input cpu_pkg::reg_idx_t rt);
        cpu_pkg::instr_t w;
        w.r_fmt.op = op;
        w.r_fmt.rd = rd;
        w.r_fmt.rs = rs;
        w.r_fmt.rt = rt;
        return w;
    endfunction

    function automatic cpu_pkg::instr_t i_word(input cpu_pkg::opcode_t op,
                                               input cpu_pkg::reg_idx_t rd,
                                               input logic [7:0] imm8);
        cpu_pkg::instr_t w;
        w.i_fmt.op   = op;
        w.i_fmt.rd   = rd;
        w.i_fmt.imm8 = imm8;
        return w;
    endfunction

    // Unused words are NOPs tagged with their own address
    function automatic cpu_pkg::instr_t nop_word(input int a);
        return r_word(cpu_pkg::NOP, a[11:8], a[7:4], a[3:0]);
    endfunction

    task automatic emit(input cpu_pkg::instr_t w);
        if (prog_len >= `IMEM_DEPTH)
        begin
            $display("The test program does not fit into instruction memory");
            abort_run();
        end
        image[prog_len] = w;
        prog_len++;
    endtask

    task automatic set_reg(input cpu_pkg::reg_idx_t rd, input cpu_pkg::word_t v);
        if (rd != 4'd0)
            model_regs[rd] = v;
    endtask

    task automatic alu_op(input cpu_pkg::opcode_t op, input cpu_pkg::reg_idx_t rd,
                          input cpu_pkg::reg_idx_t rs, input cpu_pkg::reg_idx_t rt);
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        cpu_pkg::word_t v;
        a = model_regs[rs];
        b = model_regs[rt];
        case (op)
            cpu_pkg::ADD: v = a + b;
            cpu_pkg::SUB: v = a - b;
            cpu_pkg::AND: v = a & b;
            cpu_pkg::OR:  v = a | b;
            default:      v = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
        endcase
        emit(r_word(op, rd, rs, rt));
        set_reg(rd, v);
    endtask

    task automatic load_imm(input cpu_pkg::reg_idx_t rd, input logic [7:0] imm8);
        emit(i_word(cpu_pkg::LI, rd, imm8));
        set_reg(rd, {{8{imm8[7]}}, imm8});
    endtask

    task automatic add_imm(input cpu_pkg::reg_idx_t rd, input logic [7:0] imm8);
        emit(i_word(cpu_pkg::ADDI, rd, imm8));
        set_reg(rd, model_regs[rd] + {{8{imm8[7]}}, imm8});
    endtask

    task automatic store_word(input cpu_pkg::reg_idx_t rd, input cpu_pkg::reg_idx_t rs,
                              input logic [3:0] off);
        cpu_pkg::word_t addr;
        addr = model_regs[rs] + {{12{off[3]}}, off};
        model_mem[addr[7:0]] = model_regs[rd];
        emit(r_word(cpu_pkg::SW, rd, rs, off));
    endtask

    task automatic load_word(input cpu_pkg::reg_idx_t rd, input cpu_pkg::reg_idx_t rs,
                             input logic [3:0] off);
        cpu_pkg::word_t addr;
        addr = model_regs[rs] + {{12{off[3]}}, off};
        emit(r_word(cpu_pkg::LW, rd, rs, off));
        set_reg(rd, model_mem[addr[7:0]]);
    endtask

    // r15 holds the output address in every program
    task automatic store_io(input cpu_pkg::reg_idx_t rx);
        emit(r_word(cpu_pkg::SW, rx, 4'd15, 4'd0));
    endtask

    task automatic output_reg(input cpu_pkg::reg_idx_t rx);
        store_io(rx);
        expected.push_back(model_regs[rx]);
    endtask

    task automatic halt_core();
        emit(i_word(cpu_pkg::HALT, 4'd0, 8'h00));
    endtask

    task automatic start_program();
        int i;
        prog_len = 0;
        expected.delete();
        for (i = 0; i < `CPU_REGS; i++)
            model_regs[i] = '0;
        for (i = 0; i < `DMEM_DEPTH; i++)
            model_mem[i] = '0;
        load_imm(4'd15, 8'hFF);
    endtask

    ////////////////////////////////////////////////////////////
    // Loading and running
    ////////////////////////////////////////////////////////////

    task automatic load_program();
        int a;
        @(posedge clk);
        reset <= 1'b1;
        for (a = 0; a < `IMEM_DEPTH; a++)
        begin
            prog_we   <= 1'b1;
            prog_addr <= a[15:0];
            prog_data <= (a < prog_len) ? image[a] : nop_word(a);
            @(posedge clk);
        end
        prog_we <= 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic run_until_halt(input int limit);
        int  cycles;
        logic done;
        got.delete();
        cycles = 0;
        done   = 1'b0;
        @(negedge clk);
        check_halted(1'b0, halted);
        while (!done)
        begin
            if (io_valid)
                got.push_back(io_data);
            if (halted)
                done = 1'b1;
            else if (cycles >= limit)
            begin
                $display("Timeout after %0d cycles while waiting for halted", limit);
                abort_run();
            end
            else
            begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    task automatic check_absent(input cpu_pkg::word_t marker);
        int i;
        for (i = 0; i < got.size(); i++)
        begin
            if (got[i] == marker)
            begin
                $display("Marker %h reached the output though its store was skipped", marker);
                abort_run();
            end
        end
    endtask

    task automatic run_program(input int limit);
        load_program();
        run_until_halt(limit);
    endtask

    task automatic compare_outputs();
        int i;
        check_count("io_valid count", expected.size(), got.size());
        for (i = 0; i < expected.size(); i++)
            check_word($sformatf("io_data[%0d]", i), expected[i], got[i]);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic alu_chain();
        start_program();
        load_imm(4'd1, 8'h07);
        load_imm(4'd2, 8'h05);
        alu_op(cpu_pkg::ADD, 4'd3, 4'd1, 4'd2);
        output_reg(4'd3);
        alu_op(cpu_pkg::SUB, 4'd4, 4'd3, 4'd1);
        output_reg(4'd4);
        alu_op(cpu_pkg::AND, 4'd5, 4'd4, 4'd3);
        output_reg(4'd5);
        alu_op(cpu_pkg::OR, 4'd6, 4'd5, 4'd4);
        output_reg(4'd6);
        alu_op(cpu_pkg::SLT, 4'd7, 4'd4, 4'd1);
        output_reg(4'd7);
        // Signed compare against a negative value
        load_imm(4'd8, 8'hFD);
        alu_op(cpu_pkg::SLT, 4'd9, 4'd8, 4'd1);
        output_reg(4'd9);
        alu_op(cpu_pkg::SLT, 4'd10, 4'd1, 4'd8);
        output_reg(4'd10);
        add_imm(4'd3, 8'hEC);
        output_reg(4'd3);
        alu_op(cpu_pkg::ADD, 4'd11, 4'd3, 4'd3);
        alu_op(cpu_pkg::SUB, 4'd12, 4'd11, 4'd3);
        output_reg(4'd12);
        halt_core();
        run_program(300);
        compare_outputs();
    endtask

    task automatic load_use();
        start_program();
        load_imm(4'd1, 8'h44);
        load_imm(4'd2, 8'h10);
        load_imm(4'd6, 8'h03);
        store_word(4'd1, 4'd2, 4'h2);
        load_word(4'd4, 4'd2, 4'h2);
        alu_op(cpu_pkg::ADD, 4'd5, 4'd4, 4'd6);
        output_reg(4'd5);
        // Loaded value used directly as store data
        load_word(4'd7, 4'd2, 4'h2);
        output_reg(4'd7);
        store_word(4'd6, 4'd2, 4'hF);
        load_word(4'd8, 4'd2, 4'hF);
        add_imm(4'd8, 8'h05);
        output_reg(4'd8);
        halt_core();
        run_program(300);
        compare_outputs();
    endtask

    task automatic branch_paths();
        start_program();
        load_imm(4'd1, 8'h00);
        load_imm(4'd2, 8'h09);
        load_imm(4'd10, 8'h7E);
        load_imm(4'd11, 8'h6D);
        emit(i_word(cpu_pkg::BEQZ, 4'd1, 8'd2));
        store_io(4'd10);
        store_io(4'd11);
        output_reg(4'd2);
        emit(i_word(cpu_pkg::BNEZ, 4'd1, 8'd2));
        load_imm(4'd3, 8'h21);
        output_reg(4'd3);
        load_imm(4'd4, 8'h05);
        emit(i_word(cpu_pkg::BNEZ, 4'd4, 8'd2));
        store_io(4'd10);
        store_io(4'd11);
        output_reg(4'd4);
        emit(i_word(cpu_pkg::BEQZ, 4'd2, 8'd2));
        load_imm(4'd5, 8'h31);
        output_reg(4'd5);
        // Backward loop counting r6 down from 3
        load_imm(4'd6, 8'h03);
        emit(i_word(cpu_pkg::ADDI, 4'd6, 8'hFF));
        store_io(4'd6);
        emit(i_word(cpu_pkg::BNEZ, 4'd6, 8'hFD));
        expected.push_back(16'h0002);
        expected.push_back(16'h0001);
        expected.push_back(16'h0000);
        output_reg(4'd2);
        halt_core();
        run_program(300);
        check_absent(16'h007E);
        check_absent(16'h006D);
        compare_outputs();
    endtask

    task automatic register_zero();
        start_program();
        load_imm(4'd1, 8'h12);
        load_imm(4'd2, 8'h34);
        load_imm(4'd0, 8'h33);
        alu_op(cpu_pkg::ADD, 4'd3, 4'd0, 4'd1);
        output_reg(4'd3);
        alu_op(cpu_pkg::ADD, 4'd0, 4'd1, 4'd2);
        output_reg(4'd0);
        add_imm(4'd0, 8'h07);
        output_reg(4'd0);
        alu_op(cpu_pkg::OR, 4'd4, 4'd0, 4'd2);
        output_reg(4'd4);
        halt_core();
        run_program(300);
        compare_outputs();
    endtask

    task automatic random_arith();
        int unsigned       draw;
        int                n;
        int                kind;
        cpu_pkg::reg_idx_t rd;
        cpu_pkg::reg_idx_t rs;
        cpu_pkg::reg_idx_t rt;
        start_program();
        for (n = 1; n <= 8; n++)
        begin
            draw = $urandom;
            load_imm(n[3:0], draw[7:0]);
        end
        for (n = 0; n < 24; n++)
        begin
            draw = $urandom_range(1, 8);
            rd   = draw[3:0];
            draw = $urandom_range(1, 8);
            rs   = draw[3:0];
            draw = $urandom_range(1, 8);
            rt   = draw[3:0];
            kind = $urandom_range(0, 2);
            if (kind == 0)
                alu_op(cpu_pkg::ADD, rd, rs, rt);
            else if (kind == 1)
                alu_op(cpu_pkg::SUB, rd, rs, rt);
            else
            begin
                draw = $urandom;
                add_imm(rd, draw[7:0]);
            end
            output_reg(rd);
        end
        halt_core();
        run_program(500);
        compare_outputs();
    endtask

    task automatic halt_stop();
        int n;
        start_program();
        load_imm(4'd1, 8'h2A);
        load_imm(4'd12, 8'h5C);
        // HALT in the shadow of a taken branch is squashed
        emit(i_word(cpu_pkg::BEQZ, 4'd0, 8'd1));
        halt_core();
        output_reg(4'd1);
        halt_core();
        store_io(4'd12);
        store_io(4'd12);
        run_program(300);
        check_absent(16'h005C);
        compare_outputs();
        for (n = 0; n < 50; n++)
        begin
            @(negedge clk);
            if (io_valid)
            begin
                $display("io_valid pulsed %0d cycles after the core halted", n);
                abort_run();
            end
        end
        check_halted(1'b1, halted);
    endtask

    initial
    begin
        int unsigned seed_draw;
        clk         = 1'b0;
        reset       = 1'b1;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        prog_len    = 0;
        seed_draw   = $urandom(32'hb1cd);
        alu_chain();
        load_use();
        branch_paths();
        register_zero();
        random_arith();
        halt_stop();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
